// ==== design/hmr_pkg.sv ====
/*
 * HMR shared definitions
 * Core payload structs, configuration port widths and the register map
 * of the triple-modular-redundancy wrapper
 */

package hmr_pkg;

  // Configuration port
  parameter int unsigned CfgAddrWidth  = 4;
  parameter int unsigned CfgDataWidth  = 32;
  parameter int unsigned MismatchWidth = 8;

  // Cores in one TMR group, core 3g is the main core
  parameter int unsigned CoresPerGrp = 3;

  // Register map, word addresses
  parameter logic [CfgAddrWidth-1:0] RegTmrEnable    = 4'd0;
  parameter logic [CfgAddrWidth-1:0] RegMismatchBase = 4'd4;

  // Inputs fanned out to the cores
  typedef struct packed {
    logic        irq;
    logic [31:0] boot_addr;
  } all_inputs_t;

  // Core outputs voted by the main voter
  typedef struct packed {
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        core_busy;
  } nominal_outputs_t;

  // Data bus outputs, voted separately
  typedef struct packed {
    logic        data_req;
    logic        data_we;
    logic [3:0]  data_be;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
  } bus_outputs_t;

endpackage

// ==== design/hmr_cfg_if.sv ====
/*
 * HMR configuration interface
 * Four-phase req/ack register access between the top level and the
 * register block
 */

`timescale 1ns/1ps

interface hmr_cfg_if import hmr_pkg::*; ();

  logic                    req;
  logic                    we;
  logic [CfgAddrWidth-1:0] addr;
  logic [CfgDataWidth-1:0] wdata;
  logic                    ack;
  logic [CfgDataWidth-1:0] rdata;

  modport master (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport slave (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// ==== design/hmr_tmr_voter.sv ====
/*
 * Bitwise TMR majority voter
 * Votes three copies of one payload and flags which copies disagree
 */

`timescale 1ns/1ps

module hmr_tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t   a_i,
  input  payload_t   b_i,
  input  payload_t   c_i,
  output payload_t   majority_o,
  output logic [2:0] error_cba_o,
  output logic       failure_o
);

  payload_t majority;

  // Two out of three per bit
  assign majority = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  assign majority_o = majority;

  // Bit k flags core k
  assign error_cba_o[0] = (a_i != majority);
  assign error_cba_o[1] = (b_i != majority);
  assign error_cba_o[2] = (c_i != majority);

  // No two copies agree
  assign failure_o = (a_i != b_i) && (a_i != c_i) && (b_i != c_i);

endmodule

// ==== design/hmr_tmr_group.sv ====
/*
 * HMR TMR group
 * Votes the nominal and bus outputs of three cores and merges their
 * error flags, bus errors only while bus voting is enabled
 */

`timescale 1ns/1ps

module hmr_tmr_group import hmr_pkg::*; (
  input  logic                                tmr_en_i,
  input  logic                                bus_vote_en_i,
  input  nominal_outputs_t [CoresPerGrp-1:0]  nominal_i,
  input  bus_outputs_t     [CoresPerGrp-1:0]  bus_i,
  output nominal_outputs_t                    voted_nominal_o,
  output bus_outputs_t                        voted_bus_o,
  output logic [CoresPerGrp-1:0]              error_o,
  output logic                                failure_o,
  output logic [CoresPerGrp-1:0]              mismatch_o
);

  logic [CoresPerGrp-1:0] nom_error;
  logic [CoresPerGrp-1:0] bus_error;
  logic                   nom_failure;
  logic                   bus_failure;
  logic [CoresPerGrp-1:0] grp_error;

  hmr_tmr_voter #(
    .payload_t   ( nominal_outputs_t )
  ) nominal_voter_inst (
    .a_i         ( nominal_i[0]      ),
    .b_i         ( nominal_i[1]      ),
    .c_i         ( nominal_i[2]      ),
    .majority_o  ( voted_nominal_o   ),
    .error_cba_o ( nom_error         ),
    .failure_o   ( nom_failure       )
  );

  // Bus is always voted, only its flags are gated
  hmr_tmr_voter #(
    .payload_t   ( bus_outputs_t )
  ) bus_voter_inst (
    .a_i         ( bus_i[0]      ),
    .b_i         ( bus_i[1]      ),
    .c_i         ( bus_i[2]      ),
    .majority_o  ( voted_bus_o   ),
    .error_cba_o ( bus_error     ),
    .failure_o   ( bus_failure   )
  );

  // Independent groups report nothing
  assign grp_error = tmr_en_i ? (nom_error | (bus_vote_en_i ? bus_error : '0)) : '0;
  assign failure_o = tmr_en_i && (nom_failure || (bus_vote_en_i && bus_failure));

  assign error_o    = grp_error;
  assign mismatch_o = grp_error;

endmodule

// ==== design/hmr_core_steer.sv ====
/*
 * HMR core steering
 * Fans system inputs out to the cores and selects between voted and
 * per-core outputs on the system ports, per group mode
 */

`timescale 1ns/1ps

module hmr_core_steer import hmr_pkg::*; #(
  parameter int unsigned NumTmrGroups = 2
) (
  input  logic             [NumTmrGroups-1:0]             tmr_enable_i,
  input  all_inputs_t      [NumTmrGroups*CoresPerGrp-1:0] sys_inputs_i,
  output all_inputs_t      [NumTmrGroups*CoresPerGrp-1:0] core_inputs_o,
  input  nominal_outputs_t [NumTmrGroups*CoresPerGrp-1:0] core_nominal_i,
  input  bus_outputs_t     [NumTmrGroups*CoresPerGrp-1:0] core_bus_i,
  input  nominal_outputs_t [NumTmrGroups-1:0]             voted_nominal_i,
  input  bus_outputs_t     [NumTmrGroups-1:0]             voted_bus_i,
  output nominal_outputs_t [NumTmrGroups*CoresPerGrp-1:0] sys_nominal_o,
  output bus_outputs_t     [NumTmrGroups*CoresPerGrp-1:0] sys_bus_o
);

  localparam int unsigned NumCores = NumTmrGroups * CoresPerGrp;

  for (genvar c = 0; c < NumCores; c++) begin : gen_core
    localparam int unsigned Grp  = c / CoresPerGrp;
    localparam int unsigned Main = Grp * CoresPerGrp;

    // All three cores follow the main core's inputs in TMR mode
    assign core_inputs_o[c] = tmr_enable_i[Grp] ? sys_inputs_i[Main] : sys_inputs_i[c];

    always_comb begin
      if (!tmr_enable_i[Grp]) begin
        sys_nominal_o[c] = core_nominal_i[c];
        sys_bus_o[c]     = core_bus_i[c];
      end else if (c == Main) begin
        sys_nominal_o[c] = voted_nominal_i[Grp];
        sys_bus_o[c]     = voted_bus_i[Grp];
      end else begin
        // Secondary ports are silenced
        sys_nominal_o[c] = '0;
        sys_bus_o[c]     = '0;
      end
    end
  end

endmodule

// ==== design/hmr_cfg_regs.sv ====
/*
 * HMR configuration registers
 * Four-phase register slave with the per-group TMR mode bits and one
 * saturating mismatch counter per core
 */

`timescale 1ns/1ps

module hmr_cfg_regs import hmr_pkg::*; #(
  parameter int unsigned NumTmrGroups = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  hmr_cfg_if.slave                cfg,
  input  logic [NumTmrGroups*CoresPerGrp-1:0] mismatch_i,
  output logic [NumTmrGroups-1:0] tmr_enable_o
);

  localparam int unsigned NumCores = NumTmrGroups * CoresPerGrp;

  logic                                   ack_q;
  logic [CfgDataWidth-1:0]                rdata_q;
  logic [NumTmrGroups-1:0]                tmr_en_q;
  logic [NumCores-1:0][MismatchWidth-1:0] cnt_q;

  logic                    req_start;
  logic                    wr_en;
  logic [NumCores-1:0]     cnt_sel;
  logic [CfgDataWidth-1:0] rd_data;

  // A new access is accepted only while ack is low
  assign req_start = cfg.req && !ack_q;
  assign wr_en     = req_start && cfg.we;

  // Address decode and read mux, unmapped addresses read zero
  always_comb begin
    rd_data = '0;
    for (int c = 0; c < NumCores; c++) begin
      cnt_sel[c] = (cfg.addr == RegMismatchBase + CfgAddrWidth'(c));
    end
    if (cfg.addr == RegTmrEnable) begin
      rd_data[NumTmrGroups-1:0] = tmr_en_q;
    end
    for (int c = 0; c < NumCores; c++) begin
      if (cnt_sel[c]) begin
        rd_data[MismatchWidth-1:0] = cnt_q[c];
      end
    end
  end

  // Handshake, read capture and mode register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      rdata_q  <= '0;
      tmr_en_q <= '0;
    end else begin
      if (req_start) begin
        ack_q   <= 1'b1;
        rdata_q <= cfg.we ? '0 : rd_data;
        if (cfg.we && cfg.addr == RegTmrEnable) begin
          tmr_en_q <= cfg.wdata[NumTmrGroups-1:0];
        end
      end else if (!cfg.req && ack_q) begin
        ack_q <= 1'b0;
      end
    end
  end

  // Mismatch counters, a write clears and wins over an increment
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int c = 0; c < NumCores; c++) begin
        if (wr_en && cnt_sel[c]) begin
          cnt_q[c] <= '0;
        end else if (mismatch_i[c] && cnt_q[c] != '1) begin
          cnt_q[c] <= cnt_q[c] + MismatchWidth'(1);
        end
      end
    end
  end

  assign cfg.ack      = ack_q;
  assign cfg.rdata    = rdata_q;
  assign tmr_enable_o = tmr_en_q;

endmodule

// ==== design/hmr_unit.sv ====
/*
 * HMR unit
 * TMR wrapper for groups of three cores, with software-selected mode,
 * bitwise voting, error reporting and a register port
 */

`timescale 1ns/1ps

module hmr_unit import hmr_pkg::*; #(
  parameter int unsigned NumTmrGroups = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Configuration port
  input  logic                    cfg_req_i,
  input  logic                    cfg_we_i,
  input  logic [CfgAddrWidth-1:0] cfg_addr_i,
  input  logic [CfgDataWidth-1:0] cfg_wdata_i,
  output logic                    cfg_ack_o,
  output logic [CfgDataWidth-1:0] cfg_rdata_o,

  // System side
  input  all_inputs_t      [NumTmrGroups*CoresPerGrp-1:0] sys_inputs_i,
  output nominal_outputs_t [NumTmrGroups*CoresPerGrp-1:0] sys_nominal_outputs_o,
  output bus_outputs_t     [NumTmrGroups*CoresPerGrp-1:0] sys_bus_outputs_o,
  input  logic             [NumTmrGroups-1:0]             enable_bus_vote_i,

  // Core side
  output all_inputs_t      [NumTmrGroups*CoresPerGrp-1:0] core_inputs_o,
  input  nominal_outputs_t [NumTmrGroups*CoresPerGrp-1:0] core_nominal_outputs_i,
  input  bus_outputs_t     [NumTmrGroups*CoresPerGrp-1:0] core_bus_outputs_i,

  output logic [NumTmrGroups*CoresPerGrp-1:0] tmr_error_o,
  output logic [NumTmrGroups-1:0]             tmr_failure_o
);

  localparam int unsigned NumCores = NumTmrGroups * CoresPerGrp;

  logic             [NumTmrGroups-1:0] tmr_enable;
  logic             [NumCores-1:0]     mismatch;
  nominal_outputs_t [NumTmrGroups-1:0] voted_nominal;
  bus_outputs_t     [NumTmrGroups-1:0] voted_bus;

  hmr_cfg_if cfg_bus ();

  assign cfg_bus.req   = cfg_req_i;
  assign cfg_bus.we    = cfg_we_i;
  assign cfg_bus.addr  = cfg_addr_i;
  assign cfg_bus.wdata = cfg_wdata_i;
  assign cfg_ack_o     = cfg_bus.ack;
  assign cfg_rdata_o   = cfg_bus.rdata;

  hmr_cfg_regs #(
    .NumTmrGroups ( NumTmrGroups )
  ) cfg_regs_inst (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .cfg          ( cfg_bus    ),
    .mismatch_i   ( mismatch   ),
    .tmr_enable_o ( tmr_enable )
  );

  for (genvar g = 0; g < NumTmrGroups; g++) begin : gen_group
    hmr_tmr_group tmr_group_inst (
      .tmr_en_i        ( tmr_enable[g]                                   ),
      .bus_vote_en_i   ( enable_bus_vote_i[g]                            ),
      .nominal_i       ( core_nominal_outputs_i[g*CoresPerGrp +: CoresPerGrp] ),
      .bus_i           ( core_bus_outputs_i[g*CoresPerGrp +: CoresPerGrp]     ),
      .voted_nominal_o ( voted_nominal[g]                                ),
      .voted_bus_o     ( voted_bus[g]                                    ),
      .error_o         ( tmr_error_o[g*CoresPerGrp +: CoresPerGrp]       ),
      .failure_o       ( tmr_failure_o[g]                                ),
      .mismatch_o      ( mismatch[g*CoresPerGrp +: CoresPerGrp]          )
    );
  end

  hmr_core_steer #(
    .NumTmrGroups    ( NumTmrGroups )
  ) core_steer_inst (
    .tmr_enable_i    ( tmr_enable             ),
    .sys_inputs_i    ( sys_inputs_i           ),
    .core_inputs_o   ( core_inputs_o          ),
    .core_nominal_i  ( core_nominal_outputs_i ),
    .core_bus_i      ( core_bus_outputs_i     ),
    .voted_nominal_i ( voted_nominal          ),
    .voted_bus_i     ( voted_bus              ),
    .sys_nominal_o   ( sys_nominal_outputs_o  ),
    .sys_bus_o       ( sys_bus_outputs_o      )
  );

endmodule

// ==== verif/hmr_unit_chk.sv ====
/*
 * HMR unit assertions
 * Checks the configuration handshake and the silencing of secondary
 * system ports in TMR mode
 */

`timescale 1ns/1ps

module hmr_unit_chk import hmr_pkg::*; #(
  parameter int unsigned NumTmrGroups = 2
) (
  input logic                                            clk_i,
  input logic                                            rst_n_i,
  input logic                                            cfg_req_i,
  input logic                                            cfg_ack_i,
  input logic             [NumTmrGroups-1:0]             tmr_enable_i,
  input nominal_outputs_t [NumTmrGroups*CoresPerGrp-1:0] sys_nominal_i,
  input bus_outputs_t     [NumTmrGroups*CoresPerGrp-1:0] sys_bus_i
);

  // Ack answers a request seen on the previous edge
  ack_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(cfg_ack_i) |-> $past(cfg_req_i)
  ) else $error("Config ack rose without a request");

  ack_holds : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (cfg_req_i && cfg_ack_i) |=> cfg_ack_i
  ) else $error("Config ack dropped while req was still high");

  for (genvar g = 0; g < NumTmrGroups; g++) begin : gen_grp
    // Only the main port of a TMR group carries data
    secondary_zero : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) tmr_enable_i[g] |->
        (sys_nominal_i[g*CoresPerGrp+1] == '0) && (sys_nominal_i[g*CoresPerGrp+2] == '0) &&
        (sys_bus_i[g*CoresPerGrp+1] == '0) && (sys_bus_i[g*CoresPerGrp+2] == '0)
    ) else $error("Secondary port of group %0d not zero in TMR mode", g);
  end

endmodule

// ==== verif/hmr_unit_tb.sv ====
/*
 * HMR unit testbench
 * Directed tests of mode switching, voting, error flags and the
 * mismatch counters through the register port
 */

`timescale 1ns/1ps

module hmr_unit_tb import hmr_pkg::*; ();

  localparam int unsigned NumTmrGroups  = 2;
  localparam int unsigned NumCores      = NumTmrGroups * CoresPerGrp;
  localparam int          TimeoutCycles = 2000;
  localparam int          CntMax        = 2**MismatchWidth - 1;

  logic                            clk;
  logic                            rst_n;
  logic                            cfg_req;
  logic                            cfg_we;
  logic [CfgAddrWidth-1:0]         cfg_addr;
  logic [CfgDataWidth-1:0]         cfg_wdata;
  logic                            cfg_ack;
  logic [CfgDataWidth-1:0]         cfg_rdata;
  all_inputs_t      [NumCores-1:0] sys_inputs;
  all_inputs_t      [NumCores-1:0] core_inputs;
  nominal_outputs_t [NumCores-1:0] sys_nominal;
  nominal_outputs_t [NumCores-1:0] core_nominal;
  bus_outputs_t     [NumCores-1:0] sys_bus;
  bus_outputs_t     [NumCores-1:0] core_bus;
  logic [NumTmrGroups-1:0]         enable_bus_vote;
  logic [NumCores-1:0]             tmr_error;
  logic [NumTmrGroups-1:0]         tmr_failure;

  integer           seed = 32'h28c3;
  int               cycles = 0;
  int               exp_cnt [NumCores];
  logic             tmr_exp;
  nominal_outputs_t nv;
  bus_outputs_t     bv;

  hmr_unit #(
    .NumTmrGroups           ( NumTmrGroups    )
  ) hmr_unit_inst (
    .clk_i                  ( clk             ),
    .rst_n_i                ( rst_n           ),
    .cfg_req_i              ( cfg_req         ),
    .cfg_we_i               ( cfg_we          ),
    .cfg_addr_i             ( cfg_addr        ),
    .cfg_wdata_i            ( cfg_wdata       ),
    .cfg_ack_o              ( cfg_ack         ),
    .cfg_rdata_o            ( cfg_rdata       ),
    .sys_inputs_i           ( sys_inputs      ),
    .sys_nominal_outputs_o  ( sys_nominal     ),
    .sys_bus_outputs_o      ( sys_bus         ),
    .enable_bus_vote_i      ( enable_bus_vote ),
    .core_inputs_o          ( core_inputs     ),
    .core_nominal_outputs_i ( core_nominal    ),
    .core_bus_outputs_i     ( core_bus        ),
    .tmr_error_o            ( tmr_error       ),
    .tmr_failure_o          ( tmr_failure     )
  );

  bind hmr_unit hmr_unit_chk #(
    .NumTmrGroups  ( NumTmrGroups          )
  ) hmr_unit_chk_inst (
    .clk_i         ( clk_i                 ),
    .rst_n_i       ( rst_n_i               ),
    .cfg_req_i     ( cfg_req_i             ),
    .cfg_ack_i     ( cfg_ack_o             ),
    .tmr_enable_i  ( tmr_enable            ),
    .sys_nominal_i ( sys_nominal_outputs_o ),
    .sys_bus_i     ( sys_bus_outputs_o     )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("TEST FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  function automatic logic [95:0] rand96();
    return {$random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  task automatic check_passthrough(input int first);
    for (int c = first; c < NumCores; c++) begin
      check(128'(core_inputs[c]), 128'(sys_inputs[c]), "core input pass-through");
      check(128'(sys_nominal[c]), 128'(core_nominal[c]), "nominal pass-through");
      check(128'(sys_bus[c]), 128'(core_bus[c]), "bus pass-through");
    end
  endtask

  task automatic wait_ack(input logic level);
    @(negedge clk);
    while (cfg_ack !== level) @(negedge clk);
  endtask

  task automatic cfg_write(input logic [CfgAddrWidth-1:0] addr,
                           input logic [CfgDataWidth-1:0] data);
    @(posedge clk);
    cfg_req   <= 1'b1;
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    wait_ack(1'b1);
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic cfg_read(input logic [CfgAddrWidth-1:0] addr,
                          output logic [CfgDataWidth-1:0] data);
    @(posedge clk);
    cfg_req  <= 1'b1;
    cfg_we   <= 1'b0;
    cfg_addr <= addr;
    wait_ack(1'b1);
    data = cfg_rdata;
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic expect_reg(input logic [CfgAddrWidth-1:0] addr, input int exp, input string what);
    logic [CfgDataWidth-1:0] rd;
    cfg_read(addr, rd);
    check(128'(rd), 128'(exp), what);
  endtask

  // Holds group 0 outputs for n cycles, checks every cycle, then returns to nv and bv
  task automatic drive_group0(input nominal_outputs_t [2:0] nom, input bus_outputs_t [2:0] bus,
                              input logic bus_en, input int n, input logic [2:0] exp_err,
                              input logic exp_fail, input nominal_outputs_t exp_nom,
                              input bus_outputs_t exp_bus);
    @(posedge clk);
    for (int c = 0; c < CoresPerGrp; c++) begin
      core_nominal[c] <= nom[c];
      core_bus[c]     <= bus[c];
    end
    enable_bus_vote[0] <= bus_en;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      check(128'(sys_nominal[0]), 128'(exp_nom), "port 0 nominal");
      check(128'(sys_bus[0]), 128'(exp_bus), "port 0 bus");
      check(128'(tmr_error[2:0]), 128'(exp_err), "group 0 error bits");
      check(128'(tmr_failure[0]), 128'(exp_fail), "group 0 failure");
      if (tmr_exp) begin
        check(128'(sys_nominal[1]), '0, "port 1 nominal in TMR");
        check(128'(sys_nominal[2]), '0, "port 2 nominal in TMR");
        check(128'(sys_bus[1]), '0, "port 1 bus in TMR");
        check(128'(sys_bus[2]), '0, "port 2 bus in TMR");
      end else begin
        check_passthrough(0);
      end
      @(posedge clk);
    end
    for (int c = 0; c < CoresPerGrp; c++) begin
      core_nominal[c] <= nv;
      core_bus[c]     <= bv;
      if (exp_err[c]) begin
        exp_cnt[c] = (exp_cnt[c] + n > CntMax) ? CntMax : exp_cnt[c] + n;
      end
    end
    enable_bus_vote[0] <= 1'b0;
  endtask

  task automatic test_reset_state();
    logic [95:0] r;
    @(negedge clk);
    check(128'(cfg_ack), '0, "ack after reset");
    check(128'(cfg_rdata), '0, "rdata after reset");
    expect_reg(RegTmrEnable, 0, "mode register after reset");
    for (int c = 0; c < NumCores; c++) begin
      expect_reg(RegMismatchBase + CfgAddrWidth'(c), 0, "counter after reset");
    end
    @(posedge clk);
    for (int c = 0; c < NumCores; c++) begin
      r = rand96();
      sys_inputs[c]   <= r[95:63];
      core_nominal[c] <= r[33:0];
      r = rand96();
      core_bus[c] <= r[69:0];
    end
    @(negedge clk);
    check_passthrough(0);
    check(128'(tmr_error), '0, "error bits in independent mode");
    check(128'(tmr_failure), '0, "failure in independent mode");
  endtask

  task automatic test_mode_switch();
    logic [95:0] r;
    @(posedge clk);
    for (int c = 0; c < CoresPerGrp; c++) begin
      core_nominal[c] <= nv;
      core_bus[c]     <= bv;
    end
    cfg_write(RegTmrEnable, 32'd1);
    tmr_exp = 1'b1;
    expect_reg(RegTmrEnable, 1, "mode register readback");
    @(posedge clk);
    for (int c = 0; c < NumCores; c++) begin
      r = rand96();
      sys_inputs[c] <= r[32:0];
    end
    @(negedge clk);
    for (int c = 0; c < CoresPerGrp; c++) begin
      check(128'(core_inputs[c]), 128'(sys_inputs[0]), "main core input fan-out");
    end
    check(128'(sys_nominal[0]), 128'(nv), "voted nominal on port 0");
    check(128'(sys_bus[0]), 128'(bv), "voted bus on port 0");
    check(128'(sys_nominal[1]), '0, "port 1 nominal in TMR");
    check(128'(sys_nominal[2]), '0, "port 2 nominal in TMR");
    check(128'(sys_bus[1]), '0, "port 1 bus in TMR");
    check(128'(sys_bus[2]), '0, "port 2 bus in TMR");
    check_passthrough(CoresPerGrp);
    check(128'(tmr_error), '0, "error bits with agreeing cores");
  endtask

  task automatic test_single_fault();
    nominal_outputs_t bad;
    bad = nv ^ (34'(rand96()) | 34'h1);
    drive_group0({nv, bad, nv}, {bv, bv, bv}, 1'b0, 5, 3'b010, 1'b0, nv, bv);
    expect_reg(RegMismatchBase + 4'd1, exp_cnt[1], "counter after short fault");
    drive_group0({nv, bad, nv}, {bv, bv, bv}, 1'b0, 260, 3'b010, 1'b0, nv, bv);
    expect_reg(RegMismatchBase + 4'd1, CntMax, "saturated counter");
    expect_reg(RegMismatchBase, 0, "counter of a healthy core");
  endtask

  task automatic test_three_way();
    nominal_outputs_t n1;
    nominal_outputs_t n2;
    bus_outputs_t     b1;
    bus_outputs_t     b2;
    // Disjoint flips keep the majority at the reference word
    n1 = nv ^ 34'h1;
    n2 = nv ^ 34'h2;
    b1 = bv ^ 70'h10;
    b2 = bv ^ 70'h20;
    drive_group0({n2, nv, n1}, {bv, bv, bv}, 1'b0, 1, 3'b101, 1'b1, nv, bv);
    drive_group0({nv, nv, nv}, {b2, bv, b1}, 1'b0, 1, 3'b000, 1'b0, nv, bv);
    drive_group0({nv, nv, nv}, {b2, bv, b1}, 1'b1, 1, 3'b101, 1'b1, nv, bv);
    drive_group0({nv, nv, nv}, {bv, b1, bv}, 1'b0, 1, 3'b000, 1'b0, nv, bv);
    drive_group0({nv, nv, nv}, {bv, b1, bv}, 1'b1, 1, 3'b010, 1'b0, nv, bv);
  endtask

  task automatic test_clear_isolation();
    for (int c = 0; c < CoresPerGrp; c++) begin
      expect_reg(RegMismatchBase + CfgAddrWidth'(c), exp_cnt[c], "counter before clear");
      cfg_write(RegMismatchBase + CfgAddrWidth'(c), 32'hffff_ffff);
      exp_cnt[c] = 0;
      expect_reg(RegMismatchBase + CfgAddrWidth'(c), 0, "counter after clear");
    end
    cfg_write(RegTmrEnable, 32'd0);
    tmr_exp = 1'b0;
    drive_group0({nv, nv ^ 34'h3, nv}, {bv, bv, bv}, 1'b1, 10, 3'b000, 1'b0, nv, bv);
    for (int c = 0; c < CoresPerGrp; c++) begin
      expect_reg(RegMismatchBase + CfgAddrWidth'(c), 0, "counter in independent mode");
    end
  endtask

  initial begin
    rst_n           <= 1'b0;
    cfg_req         <= 1'b0;
    cfg_we          <= 1'b0;
    cfg_addr        <= '0;
    cfg_wdata       <= '0;
    sys_inputs      <= '0;
    core_nominal    <= '0;
    core_bus        <= '0;
    enable_bus_vote <= '0;
    tmr_exp = 1'b0;
    for (int c = 0; c < NumCores; c++) begin
      exp_cnt[c] = 0;
    end
    nv = 34'(rand96());
    bv = 70'(rand96());
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_mode_switch();
    test_single_fault();
    test_three_way();
    test_clear_isolation();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== hmr_unit.f ====
design/hmr_pkg.sv
design/hmr_cfg_if.sv
design/hmr_tmr_voter.sv
design/hmr_tmr_group.sv
design/hmr_core_steer.sv
design/hmr_cfg_regs.sv
design/hmr_unit.sv
verif/hmr_unit_chk.sv
verif/hmr_unit_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := hmr_unit_tb
RTL_TOP    := hmr_unit
FILELIST   := hmr_unit.f
RTL_SRCS   := $(shell grep '^design/' $(FILELIST))
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST OK
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
